//--- build.f
hdl/ice_app_pkg.sv
hdl/spi_msg_if.sv
hdl/spi_pin_sync.sv
hdl/spi_frame_engine.sv
hdl/msg_decoder.sv
hdl/ice_app_top.sv
bench/ice_app_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0 --timescale 1ns/1ps
TOP       = ice_app_tb
FILELIST  = build.f
PASS_MSG  = Simulation passed

.PHONY: sim clean

# Build and run; status comes from the pass line in the output
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir

//--- bench/ice_app_tb.sv
`default_nettype none

module ice_app_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import ice_app_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int DRIVE_DELAY  = 2;                        // ns after the img_clk edge
    localparam int SPI_HALF     = 4;                        // img_clk cycles per SPI phase
    localparam int WAIT_LIMIT   = 64;
    localparam int PARTIAL_BITS = 20;
    localparam int IDLE_HOLD    = IDLE_TIMEOUT_CYCLES + 64;

    typedef struct packed {
        logic [MSG_TYPE_LEN-1:0] msg_type;
        logic [MSG_ARG_LEN-1:0]  arg;
        logic [LED_WIDTH-1:0]    exp_led;
        logic                    exp_img_rst;
        logic                    resp_exp;
        int                      lead_zeros;
    } entry_t;

    logic                 img_clk;
    logic                 spi_rst_;
    logic                 spi_clk;
    logic                 spi_data_in;
    logic                 spi_data_out;
    logic                 spi_data_oe;
    logic [LED_WIDTH-1:0] ice_led;
    logic                 img_rst_;

    entry_t stim_q[$];
    integer seed;
    int     error_count;
    int     frame_count;

    ice_app_top i_ice_app_top (
        .img_clk      (img_clk),
        .spi_rst_     (spi_rst_),
        .spi_clk      (spi_clk),
        .spi_data_in  (spi_data_in),
        .spi_data_out (spi_data_out),
        .spi_data_oe  (spi_data_oe),
        .ice_led      (ice_led),
        .img_rst_     (img_rst_)
    );

    initial begin
        img_clk = 1'b0;
        forever #(CLK_PERIOD / 2) img_clk = ~img_clk;
    end

    // ============================================================
    // SPI host
    // ============================================================
    task automatic next_drive();
        @(posedge img_clk);
        #DRIVE_DELAY;
    endtask

    // One SPI bit, clock low then high, back to low at the end
    task automatic spi_cycle(input logic din, output logic dout, output logic doe);
        spi_data_in = din;
        repeat (SPI_HALF) next_drive();
        dout    = spi_data_out;                  // Host samples at the rising edge
        doe     = spi_data_oe;
        spi_clk = 1'b1;
        repeat (SPI_HALF) next_drive();
        spi_clk = 1'b0;
    endtask

    // Leading zeros, start bit, message, turnaround and 64 response edges
    task automatic send_frame(input msg_t msg, input int lead_zeros,
                              output resp_t resp_bits, output int oe_early,
                              output int oe_resp);
        logic [MSG_LEN-1:0] bits;
        logic               dout;
        logic               doe;
        bits      = msg;
        oe_early  = 0;
        oe_resp   = 0;
        resp_bits = '0;
        frame_count++;
        repeat (lead_zeros) begin
            spi_cycle(1'b0, dout, doe);
            if (doe !== 1'b0) oe_early++;
        end
        spi_cycle(1'b1, dout, doe);              // Start bit
        if (doe !== 1'b0) oe_early++;
        repeat (MSG_LEN) begin
            spi_cycle(bits[MSG_LEN-1], dout, doe);
            if (doe !== 1'b0) oe_early++;
            bits = bits << 1;
        end
        repeat (TURNAROUND_BITS) begin
            spi_cycle(1'b0, dout, doe);
            if (doe !== 1'b0) oe_early++;
        end
        repeat (RESP_LEN) begin
            spi_cycle(1'b0, dout, doe);
            resp_bits = {resp_bits[RESP_LEN-2:0], dout};
            if (doe === 1'b1) oe_resp++;
        end
        spi_data_in = 1'b0;
    endtask

    task automatic wait_oe_low();
        int n;
        n = 0;
        while (spi_data_oe !== 1'b0 && n < WAIT_LIMIT) begin
            next_drive();
            n++;
        end
        if (spi_data_oe !== 1'b0) begin
            $display("Timeout: spi_data_oe did not drop after the response");
            error_count++;
        end
    endtask

    // ============================================================
    // Checking helpers
    // ============================================================
    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("[ERROR] %0d ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
        error_count++;
    endtask

    function automatic logic [MSG_ARG_LEN-1:0] random_arg();
        logic [63:0] r;
        r = {$random(seed), $random(seed)};
        return r[MSG_ARG_LEN-1:0];
    endfunction

    task automatic add_entry(input logic [MSG_TYPE_LEN-1:0] t, input logic [MSG_ARG_LEN-1:0] arg,
                             input logic [LED_WIDTH-1:0] led, input logic img,
                             input logic resp, input int lz);
        entry_t e;
        e.msg_type    = t;
        e.arg         = arg;
        e.exp_led     = led;
        e.exp_img_rst = img;
        e.resp_exp    = resp;
        e.lead_zeros  = lz;
        stim_q.push_back(e);
    endtask

    task automatic build_table();
        add_entry(MSG_TYPE_LED_SET,   56'h00_0000_0000_0005, 4'h5, 1'b0, 1'b0, 0);
        add_entry(MSG_TYPE_LED_SET,   56'h12_3456_789A_BCDA, 4'hA, 1'b0, 1'b0, 3);
        add_entry(MSG_TYPE_ECHO,      random_arg(),          4'hA, 1'b0, 1'b1, 1);
        add_entry(MSG_TYPE_IMG_RESET, 56'h00_0000_0000_0001, 4'hA, 1'b1, 1'b0, 2);
        add_entry(MSG_TYPE_ECHO,      random_arg(),          4'hA, 1'b1, 1'b1, 0);
        add_entry(MSG_TYPE_LED_SET,   56'hFF_FFFF_FFFF_FFF3, 4'h3, 1'b1, 1'b0, 7);
        add_entry(MSG_TYPE_NOP,       56'hFF_FFFF_FFFF_FFFF, 4'h3, 1'b1, 1'b0, 4);
        add_entry(MSG_TYPE_IMG_RESET, 56'hFF_FFFF_FFFF_FFFE, 4'h3, 1'b0, 1'b0, 0);
        add_entry(8'h5A,              56'h00_0000_0000_000C, 4'h3, 1'b0, 1'b0, 1);
        add_entry(MSG_TYPE_ECHO,      random_arg(),          4'h3, 1'b0, 1'b1, 5);
        add_entry(8'h81,              56'hAA_5555_AAAA_5555, 4'h3, 1'b0, 1'b0, 2);  // Next to Echo
        add_entry(MSG_TYPE_LED_SET,   56'h00_0000_0000_0000, 4'h0, 1'b0, 1'b0, 6);
    endtask

    // Full frame plus the checks every table entry gets
    task automatic run_entry(input entry_t e);
        msg_t  msg;
        resp_t resp_bits;
        resp_t exp_resp;
        int    oe_early;
        int    oe_resp;
        int    exp_oe;
        msg.msg_type = e.msg_type;
        msg.arg      = e.arg;
        exp_resp     = {e.arg, 8'h00};          // Echo puts the argument on top
        exp_oe       = e.resp_exp ? RESP_LEN : 0;
        send_frame(msg, e.lead_zeros, resp_bits, oe_early, oe_resp);
        wait_oe_low();
        if (oe_early != 0) report_mismatch("spi_data_oe early edges", 64'(oe_early), 64'(0));
        if (oe_resp != exp_oe) report_mismatch("spi_data_oe response edges",
                                               64'(oe_resp), 64'(exp_oe));
        if (e.resp_exp && resp_bits !== exp_resp) report_mismatch("spi_data_out",
                                                                  resp_bits, exp_resp);
        if (ice_led !== e.exp_led) report_mismatch("ice_led", 64'(ice_led), 64'(e.exp_led));
        if (img_rst_ !== e.exp_img_rst) report_mismatch("img_rst_", 64'(img_rst_),
                                                        64'(e.exp_img_rst));
    endtask

    // ============================================================
    // Idle watchdog: stalled partial frame, then a clean frame
    // ============================================================
    task automatic idle_abort_test();
        logic [MSG_LEN-1:0]   bits;
        logic [LED_WIDTH-1:0] led_before;
        logic                 img_before;
        logic                 dout;
        logic                 doe;
        int                   glitches;
        entry_t               e;
        led_before = ice_led;
        img_before = img_rst_;
        bits       = {MSG_TYPE_LED_SET, 56'h00_0000_0000_000F};
        spi_cycle(1'b0, dout, doe);
        spi_cycle(1'b1, dout, doe);
        repeat (PARTIAL_BITS) begin
            spi_cycle(bits[MSG_LEN-1], dout, doe);
            bits = bits << 1;
        end
        spi_data_in = 1'b0;
        glitches    = 0;
        repeat (IDLE_HOLD) begin                 // spi_clk held low
            next_drive();
            if (spi_data_oe !== 1'b0 || spi_data_out !== 1'b0 ||
                ice_led !== led_before || img_rst_ !== img_before)
                glitches++;
        end
        if (glitches != 0) begin
            $display("Outputs changed during a stalled partial frame (%0d cycles)", glitches);
            error_count++;
        end
        e.msg_type    = MSG_TYPE_LED_SET;
        e.arg         = 56'h00_0000_0000_000C;
        e.exp_led     = 4'hC;
        e.exp_img_rst = img_before;
        e.resp_exp    = 1'b0;
        e.lead_zeros  = 1;
        run_entry(e);
    endtask

    // ============================================================
    // Main sequence
    // ============================================================
    initial begin
        spi_rst_    = 1'b0;
        spi_clk     = 1'b0;
        spi_data_in = 1'b0;
        seed        = 10104;
        error_count = 0;
        frame_count = 0;
        repeat (5) @(posedge img_clk);
        #DRIVE_DELAY;
        spi_rst_ = 1'b1;
        next_drive();

        if (ice_led !== '0) report_mismatch("ice_led", 64'(ice_led), 64'(0));
        if (img_rst_ !== 1'b0) report_mismatch("img_rst_", 64'(img_rst_), 64'(0));
        if (spi_data_out !== 1'b0) report_mismatch("spi_data_out", 64'(spi_data_out), 64'(0));
        if (spi_data_oe !== 1'b0) report_mismatch("spi_data_oe", 64'(spi_data_oe), 64'(0));

        build_table();
        foreach (stim_q[i]) begin
            run_entry(stim_q[i]);
        end
        idle_abort_test();

        $display("Frames sent: %0d, errors: %0d", frame_count, error_count);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/ice_app_top.sv
`default_nettype none

module ice_app_top (
    input  logic                               img_clk,
    input  logic                               spi_rst_,
    input  logic                               spi_clk,
    input  logic                               spi_data_in,
    output logic                               spi_data_out,
    output logic                               spi_data_oe,
    output logic [ice_app_pkg::LED_WIDTH-1:0]  ice_led,
    output logic                               img_rst_
);

    // Synced pin strobes
    logic rise;
    logic fall;
    logic data;

    spi_msg_if msg_bus ();

    // ============================================================
    // SPI pins into the img_clk domain
    // ============================================================
    spi_pin_sync i_spi_pin_sync (
        .img_clk     (img_clk),
        .spi_rst_    (spi_rst_),
        .spi_clk     (spi_clk),
        .spi_data_in (spi_data_in),
        .rise        (rise),
        .fall        (fall),
        .data        (data)
    );

    // ============================================================
    // Framing and command decode
    // ============================================================
    spi_frame_engine i_spi_frame_engine (
        .img_clk      (img_clk),
        .spi_rst_     (spi_rst_),
        .rise         (rise),
        .fall         (fall),
        .data         (data),
        .msg_bus      (msg_bus.engine),
        .spi_data_out (spi_data_out),
        .spi_data_oe  (spi_data_oe)
    );

    // Outputs settle 5 img_clk cycles after the last message bit
    msg_decoder i_msg_decoder (
        .img_clk  (img_clk),
        .spi_rst_ (spi_rst_),
        .msg_bus  (msg_bus.decoder),
        .ice_led  (ice_led),
        .img_rst_ (img_rst_)
    );

endmodule

`default_nettype wire

//--- hdl/msg_decoder.sv
`default_nettype none

module msg_decoder (
    input  logic                               img_clk,
    input  logic                               spi_rst_,
    spi_msg_if.decoder                         msg_bus,
    output logic [ice_app_pkg::LED_WIDTH-1:0]  ice_led,
    output logic                               img_rst_
);
    import ice_app_pkg::*;

    logic is_echo;

    assign is_echo = (msg_bus.msg.msg_type == MSG_TYPE_ECHO);

    // ============================================================
    // Command execution
    // ============================================================
    always_ff @(posedge img_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            ice_led         <= '0;
            img_rst_        <= 1'b0;             // Sensor held in reset
            msg_bus.resp_en <= 1'b0;
        end else if (msg_bus.msg_valid) begin
            case (msg_bus.msg.msg_type)
            MSG_TYPE_LED_SET: begin
                ice_led         <= msg_bus.msg.arg[LED_WIDTH-1:0];
                msg_bus.resp_en <= 1'b0;
            end

            MSG_TYPE_IMG_RESET: begin
                img_rst_        <= msg_bus.msg.arg[0];
                msg_bus.resp_en <= 1'b0;
            end

            MSG_TYPE_ECHO: begin
                msg_bus.resp_en <= 1'b1;
            end

            // Nop and unknown codes
            default: begin
                msg_bus.resp_en <= 1'b0;
            end
            endcase
        end
    end

    // Echo response, argument in the upper bits
    always_ff @(posedge img_clk) begin
        if (msg_bus.msg_valid && is_echo) begin
            msg_bus.resp <= {msg_bus.msg.arg, {(RESP_LEN - MSG_ARG_LEN){1'b0}}};
        end
    end

    // Engine hands over a fully shifted message
    assert property (@(posedge img_clk) disable iff (!spi_rst_)
        msg_bus.msg_valid |-> !$isunknown(msg_bus.msg));

endmodule

`default_nettype wire

//--- hdl/spi_frame_engine.sv
`default_nettype none

module spi_frame_engine (
    input  logic       img_clk,
    input  logic       spi_rst_,
    input  logic       rise,
    input  logic       fall,
    input  logic       data,
    spi_msg_if.engine  msg_bus,
    output logic       spi_data_out,
    output logic       spi_data_oe
);
    import ice_app_pkg::*;

    typedef enum logic [1:0] {
        ST_HUNT,        // Waiting for the start bit
        ST_MSG,
        ST_TURN,
        ST_RESP
    } frame_state_t;

    frame_state_t           state;
    logic [BIT_CNT_W-1:0]   bit_cnt;
    logic [IDLE_CNT_W-1:0]  idle_cnt;
    logic [MSG_LEN-1:0]     msg_sr;
    resp_t                  resp_sr;

    logic msg_last;
    logic turn_last;
    logic resp_done;
    logic idle_timeout;
    logic shift_in;
    logic resp_load;
    logic resp_shift;

    // ============================================================
    // Bit position decode
    // ============================================================
    assign msg_last  = (bit_cnt == BIT_CNT_W'(MSG_LEN - 1));
    assign turn_last = (bit_cnt == BIT_CNT_W'(TURNAROUND_BITS - 1));
    assign resp_done = (bit_cnt == BIT_CNT_W'(RESP_LEN));

    // No rise strobe for too long in the middle of a frame
    assign idle_timeout = (state != ST_HUNT) && !rise &&
                          (idle_cnt == IDLE_CNT_W'(IDLE_TIMEOUT_CYCLES - 1));

    assign shift_in   = (state == ST_MSG) && rise;
    assign resp_load  = (state == ST_TURN) && rise && turn_last && msg_bus.resp_en;
    assign resp_shift = (state == ST_RESP) && fall && !resp_done;

    assign msg_bus.msg = msg_t'(msg_sr);

    // ============================================================
    // Frame FSM
    // ============================================================
    always_ff @(posedge img_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            state             <= ST_HUNT;
            bit_cnt           <= '0;
            idle_cnt          <= '0;
            msg_bus.msg_valid <= 1'b0;
            spi_data_oe       <= 1'b0;
            spi_data_out      <= 1'b0;
        end else begin
            msg_bus.msg_valid <= 1'b0;              // Pulse

            if (rise || state == ST_HUNT) begin
                idle_cnt <= '0;
            end else begin
                idle_cnt <= idle_cnt + 1'b1;
            end

            if (idle_timeout) begin
                // Drop the partial frame
                state        <= ST_HUNT;
                spi_data_oe  <= 1'b0;
                spi_data_out <= 1'b0;
            end else begin
                case (state)
                ST_HUNT: begin
                    if (rise && data) begin         // First 1 is the start bit
                        state   <= ST_MSG;
                        bit_cnt <= '0;
                    end
                end

                ST_MSG: begin
                    if (rise) begin
                        if (msg_last) begin
                            state             <= ST_TURN;
                            bit_cnt           <= '0;
                            msg_bus.msg_valid <= 1'b1;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end

                ST_TURN: begin
                    if (rise) begin
                        if (turn_last) begin
                            // Decoder finished long ago
                            state   <= msg_bus.resp_en ? ST_RESP : ST_HUNT;
                            bit_cnt <= '0;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end

                ST_RESP: begin
                    if (fall) begin
                        if (resp_done) begin        // Fall after the last host sample
                            state        <= ST_HUNT;
                            spi_data_oe  <= 1'b0;
                            spi_data_out <= 1'b0;
                        end else begin
                            spi_data_oe  <= 1'b1;
                            spi_data_out <= resp_sr[RESP_LEN-1];
                            bit_cnt      <= bit_cnt + 1'b1;
                        end
                    end
                end

                default: state <= ST_HUNT;
                endcase
            end
        end
    end

    // ============================================================
    // Shift registers
    // ============================================================
    always_ff @(posedge img_clk) begin
        if (shift_in) begin
            msg_sr <= {msg_sr[MSG_LEN-2:0], data};  // MSB first
        end
    end

    always_ff @(posedge img_clk) begin
        if (resp_load) begin
            resp_sr <= msg_bus.resp;
        end else if (resp_shift) begin
            resp_sr <= {resp_sr[RESP_LEN-2:0], 1'b0};
        end
    end

    // Line belongs to the host until the turnaround is over
    assert property (@(posedge img_clk) disable iff (!spi_rst_)
        (state == ST_HUNT || state == ST_MSG) |-> !spi_data_oe);

    assert property (@(posedge img_clk) disable iff (!spi_rst_)
        msg_bus.msg_valid |=> !msg_bus.msg_valid);

endmodule

`default_nettype wire

//--- hdl/spi_pin_sync.sv
`default_nettype none

module spi_pin_sync (
    input  logic img_clk,
    input  logic spi_rst_,
    input  logic spi_clk,
    input  logic spi_data_in,
    output logic rise,
    output logic fall,
    output logic data
);

    // Bit 1 is spi_clk, bit 0 is the data pin
    logic [1:0] pin_meta;
    logic [1:0] pin_sync;
    logic       clk_prev;       // Synced clock one cycle back

    // ============================================================
    // Two-flop synchronizer and edge detect
    // ============================================================
    always_ff @(posedge img_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            pin_meta <= '0;
            pin_sync <= '0;
            clk_prev <= 1'b0;
            rise     <= 1'b0;
            fall     <= 1'b0;
            data     <= 1'b0;
        end else begin
            pin_meta <= {spi_clk, spi_data_in};
            pin_sync <= pin_meta;
            clk_prev <= pin_sync[1];

            rise <= pin_sync[1] && !clk_prev;
            fall <= !pin_sync[1] && clk_prev;

            // Extra stage so data lines up with rise
            data <= pin_sync[0];
        end
    end

    // Host keeps data steady while spi_clk rises
    assert property (@(posedge img_clk) disable iff (!spi_rst_)
        (pin_sync[1] && !clk_prev) |-> (pin_sync[0] == data));

endmodule

`default_nettype wire

//--- hdl/spi_msg_if.sv
`default_nettype none

interface spi_msg_if;
    import ice_app_pkg::*;

    logic  msg_valid;   // One-cycle pulse per message
    msg_t  msg;         // Held until the next start bit
    resp_t resp;
    logic  resp_en;     // Send resp after the turnaround

    modport engine (
        output msg_valid,
        output msg,
        input  resp,
        input  resp_en
    );

    modport decoder (
        input  msg_valid,
        input  msg,
        output resp,
        output resp_en
    );

endinterface

`default_nettype wire

//--- hdl/ice_app_pkg.sv
`default_nettype none

package ice_app_pkg;

    // ============================================================
    // Frame geometry
    // ============================================================
    localparam int MSG_LEN         = 64;
    localparam int RESP_LEN        = 64;
    localparam int MSG_TYPE_LEN    = 8;                     // Top byte of a message
    localparam int MSG_ARG_LEN     = MSG_LEN - MSG_TYPE_LEN;
    localparam int TURNAROUND_BITS = 8;                     // Rising edges before response

    // Counts up to RESP_LEN in the response phase
    localparam int BIT_CNT_W = $clog2(RESP_LEN + 1);

    // ============================================================
    // Idle watchdog
    // ============================================================
    localparam int IDLE_TIMEOUT_CYCLES = 256;               // img_clk cycles
    localparam int IDLE_CNT_W          = $clog2(IDLE_TIMEOUT_CYCLES);

    localparam int LED_WIDTH = 4;

    // ============================================================
    // Message types
    // ============================================================
    localparam logic [MSG_TYPE_LEN-1:0] MSG_TYPE_NOP       = 8'h00;
    localparam logic [MSG_TYPE_LEN-1:0] MSG_TYPE_LED_SET   = 8'h01;
    localparam logic [MSG_TYPE_LEN-1:0] MSG_TYPE_IMG_RESET = 8'h02;
    localparam logic [MSG_TYPE_LEN-1:0] MSG_TYPE_ECHO      = 8'h80;   // Only type with a response

    // Type field goes out first on the wire
    typedef struct packed {
        logic [MSG_TYPE_LEN-1:0] msg_type;
        logic [MSG_ARG_LEN-1:0]  arg;
    } msg_t;

    typedef logic [RESP_LEN-1:0] resp_t;

endpackage

`default_nettype wire
